//--- logic/isa_pkg.sv
package isa_pkg;

  // Data-processing opcodes, bits 24:21
  typedef enum logic [3:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB,
    OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN,  // Compare/test group
    OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } opcode_e;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_e;

  typedef enum logic [1:0] {
    SH_LSL, SH_LSR, SH_ASR, SH_ROR
  } shift_e;

  localparam logic [1:0] CLASS_DP = 2'b00;  // Bits 27:26 of a data-processing word

  typedef struct packed {
    cond_e      cond;
    logic [1:0] op_class;
    logic       i_bit;
    opcode_e    opcode;
    logic       s_bit;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [4:0] shift_amt;
    shift_e     shift_type;
    logic       reg_shift;  // Bit 4
    logic [3:0] rm;
  } reg_form_t;

  typedef struct packed {
    cond_e      cond;
    logic [1:0] op_class;
    logic       i_bit;
    opcode_e    opcode;
    logic       s_bit;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rotate;
    logic [7:0] imm8;
  } imm_form_t;

  // Same word, operand 2 read either as shifted Rm or as rotated immediate
  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } dp_instr_u;

endpackage

//--- logic/core_pkg.sv
package core_pkg;

  localparam int DATA_W    = 32;
  localparam int REG_IDX_W = 4;
  localparam int NUM_REGS  = 16;

  // Bit positions in the 4-bit flags word
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  // Operand source selects
  localparam logic [1:0] FWD_RF = 2'd0;
  localparam logic [1:0] FWD_EX = 2'd1;
  localparam logic [1:0] FWD_WB = 2'd2;

endpackage

//--- logic/reg_file.sv
module reg_file (
  input  logic                           clk,
  input  logic                           i_rst_n,
  input  logic [core_pkg::REG_IDX_W-1:0] i_rd_addr_a,
  input  logic [core_pkg::REG_IDX_W-1:0] i_rd_addr_b,
  input  logic                           i_wr_en,
  input  logic [core_pkg::REG_IDX_W-1:0] i_wr_addr,
  input  logic [core_pkg::DATA_W-1:0]    i_wr_data,
  output logic [core_pkg::DATA_W-1:0]    o_rd_data_a,
  output logic [core_pkg::DATA_W-1:0]    o_rd_data_b
);

  import core_pkg::*;

  logic [DATA_W-1:0] regs [NUM_REGS];

  // R15 is a plain register and clears with the rest
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // No bypass of the write port here
  assign o_rd_data_a = regs[i_rd_addr_a];
  assign o_rd_data_b = regs[i_rd_addr_b];

endmodule

//--- logic/operand_forward.sv
module operand_forward (
  input  logic [core_pkg::REG_IDX_W-1:0] i_rn,
  input  logic [core_pkg::REG_IDX_W-1:0] i_rm,
  input  logic [core_pkg::DATA_W-1:0]    i_rf_rn_data,
  input  logic [core_pkg::DATA_W-1:0]    i_rf_rm_data,
  input  logic                           i_ex_wr_en,
  input  logic [core_pkg::REG_IDX_W-1:0] i_ex_rd,
  input  logic [core_pkg::DATA_W-1:0]    i_ex_result,
  input  logic                           i_wb_wr_en,
  input  logic [core_pkg::REG_IDX_W-1:0] i_wb_rd,
  input  logic [core_pkg::DATA_W-1:0]    i_wb_data,
  output logic [core_pkg::DATA_W-1:0]    o_rn_data,
  output logic [core_pkg::DATA_W-1:0]    o_rm_data
);

  import core_pkg::*;

  logic       rn_ex_hit;
  logic       rn_wb_hit;
  logic       rm_ex_hit;
  logic       rm_wb_hit;
  logic [1:0] rn_sel;
  logic [1:0] rm_sel;

  function automatic logic [DATA_W-1:0] sel_data(input logic [1:0]        sel,
                                                 input logic [DATA_W-1:0] rf,
                                                 input logic [DATA_W-1:0] ex,
                                                 input logic [DATA_W-1:0] wb);
    case (sel)
      FWD_EX:  return ex;
      FWD_WB:  return wb;
      default: return rf;
    endcase
  endfunction

  assign rn_ex_hit = i_ex_wr_en && (i_ex_rd == i_rn);
  assign rn_wb_hit = i_wb_wr_en && (i_wb_rd == i_rn);
  assign rm_ex_hit = i_ex_wr_en && (i_ex_rd == i_rm);
  assign rm_wb_hit = i_wb_wr_en && (i_wb_rd == i_rm);

  // Youngest producer first
  assign rn_sel = rn_ex_hit ? FWD_EX : (rn_wb_hit ? FWD_WB : FWD_RF);
  assign rm_sel = rm_ex_hit ? FWD_EX : (rm_wb_hit ? FWD_WB : FWD_RF);

  assign o_rn_data = sel_data(rn_sel, i_rf_rn_data, i_ex_result, i_wb_data);
  assign o_rm_data = sel_data(rm_sel, i_rf_rm_data, i_ex_result, i_wb_data);

endmodule

//--- logic/decode_stage.sv
module decode_stage (
  input  logic                           clk,
  input  logic                           i_rst_n,
  input  logic                           i_instr_valid,
  input  logic [31:0]                    i_instr,
  input  logic [core_pkg::DATA_W-1:0]    i_rf_rn_data,
  input  logic [core_pkg::DATA_W-1:0]    i_rf_rm_data,
  input  logic                           i_ex_wr_en,
  input  logic [core_pkg::REG_IDX_W-1:0] i_ex_rd,
  input  logic [core_pkg::DATA_W-1:0]    i_ex_result,
  input  logic                           i_wb_wr_en,
  input  logic [core_pkg::REG_IDX_W-1:0] i_wb_rd,
  input  logic [core_pkg::DATA_W-1:0]    i_wb_data,
  output logic [core_pkg::REG_IDX_W-1:0] o_rf_rn_addr,
  output logic [core_pkg::REG_IDX_W-1:0] o_rf_rm_addr,
  output logic                           o_op_valid,
  output logic [3:0]                     o_opcode,
  output logic                           o_s_bit,
  output logic [3:0]                     o_cond,
  output logic [core_pkg::REG_IDX_W-1:0] o_rd,
  output logic                           o_writes_rd,
  output logic                           o_imm_form,
  output logic [11:0]                    o_op2_field,
  output logic [core_pkg::DATA_W-1:0]    o_rn_data,
  output logic [core_pkg::DATA_W-1:0]    o_rm_data
);

  import isa_pkg::*;
  import core_pkg::*;

  logic              dec_valid;
  dp_instr_u         dec_instr;
  logic              writes_rd;
  logic [DATA_W-1:0] rn_fwd;
  logic [DATA_W-1:0] rm_fwd;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= i_instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_instr_valid) begin
      dec_instr <= i_instr;
    end
  end

  assign o_rf_rn_addr = dec_instr.reg_form.rn;
  assign o_rf_rm_addr = dec_instr.reg_form.rm;  // Ignored later for immediate form

  // Compare/test and other classes never touch Rd
  assign writes_rd = (dec_instr.reg_form.op_class == CLASS_DP) &&
                     !(dec_instr.reg_form.opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN});

  operand_forward u_operand_forward (
    .i_rn         (dec_instr.reg_form.rn),
    .i_rm         (dec_instr.reg_form.rm),
    .i_rf_rn_data (i_rf_rn_data),
    .i_rf_rm_data (i_rf_rm_data),
    .i_ex_wr_en   (i_ex_wr_en),
    .i_ex_rd      (i_ex_rd),
    .i_ex_result  (i_ex_result),
    .i_wb_wr_en   (i_wb_wr_en),
    .i_wb_rd      (i_wb_rd),
    .i_wb_data    (i_wb_data),
    .o_rn_data    (rn_fwd),
    .o_rm_data    (rm_fwd)
  );

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_op_valid <= 1'b0;
    end else begin
      o_op_valid <= dec_valid;
    end
  end

  // Decode-to-execute payload
  always_ff @(posedge clk) begin
    o_opcode    <= dec_instr.reg_form.opcode;
    o_s_bit     <= dec_instr.reg_form.s_bit;
    o_cond      <= dec_instr.reg_form.cond;
    o_rd        <= dec_instr.reg_form.rd;
    o_writes_rd <= writes_rd;
    o_imm_form  <= dec_instr.reg_form.i_bit;
    o_op2_field <= {dec_instr.imm_form.rotate, dec_instr.imm_form.imm8};
    o_rn_data   <= rn_fwd;
    o_rm_data   <= rm_fwd;
  end

endmodule

//--- logic/barrel_shifter.sv
module barrel_shifter (
  input  logic                        i_imm_form,
  input  logic [11:0]                 i_op2_field,
  input  logic [core_pkg::DATA_W-1:0] i_rm_data,
  output logic [core_pkg::DATA_W-1:0] o_operand2
);

  import isa_pkg::*;
  import core_pkg::*;

  dp_instr_u op2_view;  // Only bits 11:0 are meaningful

  function automatic logic [DATA_W-1:0] ror_word(input logic [DATA_W-1:0] value,
                                                 input logic [4:0]        amt);
    return (value >> amt) | (value << (DATA_W - amt));
  endfunction

  assign op2_view = {20'd0, i_op2_field};

  always_comb begin
    if (i_imm_form) begin
      // imm8 rotated right by twice the rotate field
      o_operand2 = ror_word({24'd0, op2_view.imm_form.imm8}, {op2_view.imm_form.rotate, 1'b0});
    end else begin
      // Zero amount is a plain pass of Rm for all four types
      case (op2_view.reg_form.shift_type)
        SH_LSL:  o_operand2 = i_rm_data << op2_view.reg_form.shift_amt;
        SH_LSR:  o_operand2 = i_rm_data >> op2_view.reg_form.shift_amt;
        SH_ASR:  o_operand2 = $signed(i_rm_data) >>> op2_view.reg_form.shift_amt;
        SH_ROR:  o_operand2 = ror_word(i_rm_data, op2_view.reg_form.shift_amt);
        default: o_operand2 = i_rm_data;
      endcase
    end
  end

endmodule

//--- logic/alu.sv
module alu (
  input  logic [3:0]                  i_opcode,
  input  logic [core_pkg::DATA_W-1:0] i_a,
  input  logic [core_pkg::DATA_W-1:0] i_b,
  input  logic                        i_carry_in,
  output logic [core_pkg::DATA_W-1:0] o_result,
  output logic                        o_n,
  output logic                        o_z,
  output logic                        o_c,
  output logic                        o_v
);

  import isa_pkg::*;
  import core_pkg::*;

  logic              is_arith;
  logic              reverse;
  logic              invert;
  logic [DATA_W-1:0] add_x;
  logic [DATA_W-1:0] add_y;
  logic              add_cin;
  logic [DATA_W:0]   sum;

  assign is_arith = i_opcode inside {[OP_SUB:OP_RSC]};
  assign reverse  = i_opcode inside {OP_RSB, OP_RSC};  // B minus A
  assign invert   = i_opcode inside {OP_SUB, OP_RSB, OP_SBC, OP_RSC};

  // Subtract as x + ~y + cin so the carry out is already not-borrow
  assign add_x = reverse ? i_b : i_a;
  assign add_y = reverse ? ~i_a : (invert ? ~i_b : i_b);

  always_comb begin
    case (i_opcode)
      OP_SUB, OP_RSB:         add_cin = 1'b1;
      OP_ADC, OP_SBC, OP_RSC: add_cin = i_carry_in;
      default:                add_cin = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {{DATA_W{1'b0}}, add_cin};

  always_comb begin
    case (i_opcode)
      OP_AND:  o_result = i_a & i_b;
      OP_EOR:  o_result = i_a ^ i_b;
      OP_ORR:  o_result = i_a | i_b;
      OP_MOV:  o_result = i_b;
      OP_BIC:  o_result = i_a & ~i_b;
      OP_MVN:  o_result = ~i_b;
      default: o_result = sum[DATA_W-1:0];  // Adder group
    endcase
  end

  assign o_n = o_result[DATA_W-1];
  assign o_z = (o_result == '0);
  assign o_c = is_arith ? sum[DATA_W] : i_carry_in;  // Old C kept by logical ops

  // Operands alike in sign, result not
  assign o_v = is_arith && (add_x[DATA_W-1] == add_y[DATA_W-1]) &&
               (sum[DATA_W-1] != add_x[DATA_W-1]);

endmodule

//--- logic/execute_stage.sv
module execute_stage (
  input  logic                           clk,
  input  logic                           i_rst_n,
  input  logic                           i_op_valid,
  input  logic [3:0]                     i_opcode,
  input  logic                           i_s_bit,
  input  logic [3:0]                     i_cond,
  input  logic [core_pkg::REG_IDX_W-1:0] i_rd,
  input  logic                           i_writes_rd,
  input  logic                           i_imm_form,
  input  logic [11:0]                    i_op2_field,
  input  logic [core_pkg::DATA_W-1:0]    i_rn_data,
  input  logic [core_pkg::DATA_W-1:0]    i_rm_data,
  output logic                           o_ex_wr_en,
  output logic [core_pkg::REG_IDX_W-1:0] o_ex_rd,
  output logic [core_pkg::DATA_W-1:0]    o_ex_result,
  output logic                           o_wb_en,
  output logic [core_pkg::REG_IDX_W-1:0] o_wb_rd,
  output logic [core_pkg::DATA_W-1:0]    o_wb_data,
  output logic [3:0]                     o_flags
);

  import isa_pkg::*;
  import core_pkg::*;

  logic [DATA_W-1:0] operand2;
  logic              alu_n;
  logic              alu_z;
  logic              alu_c;
  logic              alu_v;
  logic              ex_fire;
  logic              keep_v;
  logic [3:0]        flags_next;

  function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
    case (cond)
      COND_EQ: return f[FLAG_Z];
      COND_NE: return !f[FLAG_Z];
      COND_CS: return f[FLAG_C];
      COND_CC: return !f[FLAG_C];
      COND_MI: return f[FLAG_N];
      COND_PL: return !f[FLAG_N];
      COND_VS: return f[FLAG_V];
      COND_VC: return !f[FLAG_V];
      COND_HI: return f[FLAG_C] && !f[FLAG_Z];
      COND_LS: return !f[FLAG_C] || f[FLAG_Z];
      COND_GE: return f[FLAG_N] == f[FLAG_V];
      COND_LT: return f[FLAG_N] != f[FLAG_V];
      COND_GT: return !f[FLAG_Z] && (f[FLAG_N] == f[FLAG_V]);
      COND_LE: return f[FLAG_Z] || (f[FLAG_N] != f[FLAG_V]);
      COND_AL: return 1'b1;
      default: return 1'b0;  // NV
    endcase
  endfunction

  barrel_shifter u_barrel_shifter (
    .i_imm_form  (i_imm_form),
    .i_op2_field (i_op2_field),
    .i_rm_data   (i_rm_data),
    .o_operand2  (operand2)
  );

  alu u_alu (
    .i_opcode   (i_opcode),
    .i_a        (i_rn_data),
    .i_b        (operand2),
    .i_carry_in (o_flags[FLAG_C]),
    .o_result   (o_ex_result),
    .o_n        (alu_n),
    .o_z        (alu_z),
    .o_c        (alu_c),
    .o_v        (alu_v)
  );

  // Condition sees flags left by the instruction just ahead
  assign ex_fire    = i_op_valid && i_writes_rd && cond_holds(i_cond, o_flags);
  assign o_ex_wr_en = ex_fire;
  assign o_ex_rd    = i_rd;

  assign keep_v = !(i_opcode inside {[OP_SUB:OP_RSC]});  // Logical ops leave V

  always_comb begin
    flags_next[FLAG_N] = alu_n;
    flags_next[FLAG_Z] = alu_z;
    flags_next[FLAG_C] = alu_c;
    flags_next[FLAG_V] = keep_v ? o_flags[FLAG_V] : alu_v;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_wb_en <= 1'b0;
      o_flags <= '0;
    end else begin
      o_wb_en <= ex_fire;
      if (ex_fire && i_s_bit) o_flags <= flags_next;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_fire) begin
      o_wb_rd   <= i_rd;
      o_wb_data <= o_ex_result;
    end
  end

  // Logical ops and moves hand the old carry back from the ALU
  assert property (@(posedge clk) disable iff (!i_rst_n)
                   ex_fire && i_s_bit && keep_v |=> $stable(o_flags[FLAG_C]))
    else $error("Carry changed by a logical operation");

  // A zero result is never negative
  assert property (@(posedge clk) disable iff (!i_rst_n)
                   !(o_flags[FLAG_N] && o_flags[FLAG_Z]))
    else $error("N and Z flags set together");

endmodule

//--- logic/arm_dp_core.sv
module arm_dp_core (
  input  logic                           clk,
  input  logic                           i_rst_n,
  input  logic                           i_instr_valid,
  input  logic [31:0]                    i_instr,
  output logic                           o_wb_en,
  output logic [core_pkg::REG_IDX_W-1:0] o_wb_rd,
  output logic [core_pkg::DATA_W-1:0]    o_wb_data,
  output logic [3:0]                     o_flags
);

  import core_pkg::*;

  logic [REG_IDX_W-1:0] rf_rn_addr;
  logic [REG_IDX_W-1:0] rf_rm_addr;
  logic [DATA_W-1:0]    rf_rn_data;
  logic [DATA_W-1:0]    rf_rm_data;

  // Decode to execute
  logic                 op_valid;
  logic [3:0]           opcode;
  logic                 s_bit;
  logic [3:0]           cond;
  logic [REG_IDX_W-1:0] rd;
  logic                 writes_rd;
  logic                 imm_form;
  logic [11:0]          op2_field;
  logic [DATA_W-1:0]    rn_data;
  logic [DATA_W-1:0]    rm_data;

  // Execute result back to decode
  logic                 ex_wr_en;
  logic [REG_IDX_W-1:0] ex_rd;
  logic [DATA_W-1:0]    ex_result;

  decode_stage u_decode_stage (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .i_rf_rn_data  (rf_rn_data),
    .i_rf_rm_data  (rf_rm_data),
    .i_ex_wr_en    (ex_wr_en),
    .i_ex_rd       (ex_rd),
    .i_ex_result   (ex_result),
    .i_wb_wr_en    (o_wb_en),
    .i_wb_rd       (o_wb_rd),
    .i_wb_data     (o_wb_data),
    .o_rf_rn_addr  (rf_rn_addr),
    .o_rf_rm_addr  (rf_rm_addr),
    .o_op_valid    (op_valid),
    .o_opcode      (opcode),
    .o_s_bit       (s_bit),
    .o_cond        (cond),
    .o_rd          (rd),
    .o_writes_rd   (writes_rd),
    .o_imm_form    (imm_form),
    .o_op2_field   (op2_field),
    .o_rn_data     (rn_data),
    .o_rm_data     (rm_data)
  );

  execute_stage u_execute_stage (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_op_valid  (op_valid),
    .i_opcode    (opcode),
    .i_s_bit     (s_bit),
    .i_cond      (cond),
    .i_rd        (rd),
    .i_writes_rd (writes_rd),
    .i_imm_form  (imm_form),
    .i_op2_field (op2_field),
    .i_rn_data   (rn_data),
    .i_rm_data   (rm_data),
    .o_ex_wr_en  (ex_wr_en),
    .o_ex_rd     (ex_rd),
    .o_ex_result (ex_result),
    .o_wb_en     (o_wb_en),
    .o_wb_rd     (o_wb_rd),
    .o_wb_data   (o_wb_data),
    .o_flags     (o_flags)
  );

  // Written one edge after the write-back register
  reg_file u_reg_file (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_rd_addr_a (rf_rn_addr),
    .i_rd_addr_b (rf_rm_addr),
    .i_wr_en     (o_wb_en),
    .i_wr_addr   (o_wb_rd),
    .i_wr_data   (o_wb_data),
    .o_rd_data_a (rf_rn_data),
    .o_rd_data_b (rf_rm_data)
  );

endmodule

//--- tb/dp_model.svh
`ifndef DP_MODEL_SVH
`define DP_MODEL_SVH

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    v = {v[30:0], lfsr[0]};
  end
  return v;
endfunction

function automatic logic [31:0] model_op2(input logic i_form, input logic [11:0] f,
                                          input logic [31:0] rm);
  int amt;
  if (i_form) begin
    amt = 2 * f[11:8];
    if (amt == 0) return {24'd0, f[7:0]};
    return ({24'd0, f[7:0]} >> amt) | ({24'd0, f[7:0]} << (32 - amt));
  end
  amt = f[11:7];
  if (amt == 0) return rm;  // Any type with zero amount passes Rm
  case (f[6:5])
    2'd0:    return rm << amt;
    2'd1:    return rm >> amt;
    2'd2:    return $signed(rm) >>> amt;
    default: return (rm >> amt) | (rm << (32 - amt));
  endcase
endfunction

// Returns {N, Z, C, V, result}
function automatic logic [35:0] model_alu(input logic [3:0] op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [3:0] f);
  logic [31:0] r;
  logic [31:0] p;
  logic [31:0] q;
  logic        sub;
  logic        k;
  logic        c;
  logic        v;
  longint      wide;
  c = f[1];
  v = f[0];
  case (op)
    4'd0:    r = a & b;
    4'd1:    r = a ^ b;
    4'd12:   r = a | b;
    4'd13:   r = b;
    4'd14:   r = a & ~b;
    4'd15:   r = ~b;
    default: begin
      sub = (op != 4'd4) && (op != 4'd5);
      p = (op == 4'd3 || op == 4'd7) ? b : a;  // Reverse subtracts
      q = (op == 4'd3 || op == 4'd7) ? a : b;
      case (op)
        4'd5:       k = f[1];   // ADC adds the carry
        4'd6, 4'd7: k = !f[1];  // SBC and RSC take a borrow
        default:    k = 1'b0;
      endcase
      if (sub) begin
        r    = p - q - 32'(k);
        c    = {32'd0, p} >= {32'd0, q} + 64'(k);  // C set when nothing borrowed
        wide = longint'($signed(p)) - longint'($signed(q)) - longint'(k);
      end else begin
        r    = p + q + 32'(k);
        c    = ({32'd0, p} + {32'd0, q} + 64'(k)) > 64'hFFFF_FFFF;
        wide = longint'($signed(p)) + longint'($signed(q)) + longint'(k);
      end
      v = wide != longint'($signed(r));  // Exact result does not fit 32 bits
    end
  endcase
  return {r[31], r == 32'd0, c, v, r};
endfunction

function automatic logic cond_ok(input logic [3:0] cond, input logic [3:0] f);
  logic n;
  logic z;
  logic c;
  logic v;
  {n, z, c, v} = f;
  case (cond)
    4'd0:    return z;
    4'd1:    return !z;
    4'd2:    return c;
    4'd3:    return !c;
    4'd4:    return n;
    4'd5:    return !n;
    4'd6:    return v;
    4'd7:    return !v;
    4'd8:    return c && !z;
    4'd9:    return !c || z;
    4'd10:   return n == v;
    4'd11:   return n != v;
    4'd12:   return !z && (n == v);
    4'd13:   return z || (n != v);
    4'd14:   return 1'b1;
    default: return 1'b0;
  endcase
endfunction

`endif

//--- tb/tb_arm_dp_core.sv
module tb_arm_dp_core;

  timeunit 1ns;
  timeprecision 100ps;

  import isa_pkg::*;

  localparam real CLK_PERIOD      = 8.0;
  localparam int  NUM_RANDOM      = 400;
  localparam int  DIRECTED_SLOTS  = 48;  // Upper bound of the directed part
  localparam int  WATCHDOG_CYCLES = 3 + DIRECTED_SLOTS + NUM_RANDOM + 4 + 20;
  localparam int  EXP_DEPTH       = 1024;

  logic        clk;
  logic        i_rst_n;
  logic        i_instr_valid;
  logic [31:0] i_instr;
  logic        o_wb_en;
  logic [3:0]  o_wb_rd;
  logic [31:0] o_wb_data;
  logic [3:0]  o_flags;

  int          cyc = 0;
  logic [31:0] lfsr;
  logic [31:0] m_regs [16];
  logic [3:0]  m_flags;

  // Expected outputs per cycle, filled at issue time
  logic        exp_chk   [EXP_DEPTH];
  logic        exp_en    [EXP_DEPTH];
  logic [3:0]  exp_rd    [EXP_DEPTH];
  logic [31:0] exp_data  [EXP_DEPTH];
  logic [3:0]  exp_flags [EXP_DEPTH];

  `include "dp_model.svh"

  arm_dp_core i_arm_dp_core (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .o_wb_en       (o_wb_en),
    .o_wb_rd       (o_wb_rd),
    .o_wb_data     (o_wb_data),
    .o_flags       (o_flags)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    $display("TESTBENCH FAILED");
    $fatal(1, "Check failed");
  endtask

  assert property (@(posedge clk) exp_chk[cyc] |-> o_wb_en == exp_en[cyc])
    else report_mismatch("o_wb_en", 32'($sampled(o_wb_en)), 32'(exp_en[$sampled(cyc)]));
  assert property (@(posedge clk) exp_chk[cyc] && exp_en[cyc] |-> o_wb_rd == exp_rd[cyc])
    else report_mismatch("o_wb_rd", 32'($sampled(o_wb_rd)), 32'(exp_rd[$sampled(cyc)]));
  assert property (@(posedge clk) exp_chk[cyc] && exp_en[cyc] |-> o_wb_data == exp_data[cyc])
    else report_mismatch("o_wb_data", $sampled(o_wb_data), exp_data[$sampled(cyc)]);
  assert property (@(posedge clk) exp_chk[cyc] |-> o_flags == exp_flags[cyc])
    else report_mismatch("o_flags", 32'($sampled(o_flags)), 32'(exp_flags[$sampled(cyc)]));

  function automatic logic [31:0] enc(input logic [3:0] cond, input logic i_form,
                                      input logic [3:0] op, input logic s, input logic [3:0] rn,
                                      input logic [3:0] rd, input logic [11:0] op2);
    return {cond, 2'b00, i_form, op, s, rn, rd, op2};
  endfunction

  function automatic logic [11:0] sh(input logic [4:0] amt, input logic [1:0] typ,
                                     input logic [3:0] rm);
    return {amt, typ, 1'b0, rm};
  endfunction

  // Runs the model on one word and drives it for one cycle
  task automatic issue(input logic [31:0] w);
    logic [35:0] res;
    logic        fire;
    fire = (w[27:26] == CLASS_DP) && !(w[24:21] inside {[4'd8:4'd11]}) &&
           cond_ok(w[31:28], m_flags);
    exp_en[cyc + 3] = fire;
    if (fire) begin
      res = model_alu(w[24:21], m_regs[w[19:16]],
                      model_op2(w[25], w[11:0], m_regs[w[3:0]]), m_flags);
      m_regs[w[15:12]] = res[31:0];
      if (w[20]) m_flags = res[35:32];
      exp_rd[cyc + 3]   = w[15:12];
      exp_data[cyc + 3] = res[31:0];
    end
    exp_flags[cyc + 3] = m_flags;
    exp_chk[cyc + 3]   = 1'b1;
    i_instr_valid = 1'b1;
    i_instr       = w;
    @(posedge clk);
    #1;
  endtask

  task automatic bubble();
    exp_en[cyc + 3]    = 1'b0;
    exp_flags[cyc + 3] = m_flags;
    exp_chk[cyc + 3]   = 1'b1;
    i_instr_valid = 1'b0;
    i_instr       = rand_bits(32);
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] random_word();
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic [11:0] op2;
    cond = rand_bits(1) ? 4'(COND_AL) : 4'(rand_bits(4));
    if (cond == 4'hF) cond = 4'(COND_AL);
    cls = (rand_bits(4) == 0) ? 2'(rand_bits(2)) : 2'b00;
    op2 = 12'(rand_bits(12));
    op2[4] = 1'b0;  // Immediate shift amounts only
    return {cond, cls, 1'(rand_bits(1)), 4'(rand_bits(4)), 1'(rand_bits(1)),
            4'(rand_bits(4)), 4'(rand_bits(4)), op2};
  endfunction

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    lfsr          = 32'h195c;
    m_flags       = 4'd0;
    i_rst_n       = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = 32'd0;
    for (int i = 0; i < 16; i++) m_regs[i] = 32'd0;
    for (int i = 0; i < EXP_DEPTH; i++) begin
      exp_chk[i]   = (i >= 1 && i <= 5);  // Reset and the cycles just after
      exp_en[i]    = 1'b0;
      exp_rd[i]    = 4'd0;
      exp_data[i]  = 32'd0;
      exp_flags[i] = 4'd0;
    end
    repeat (2) @(posedge clk);
    #1;
    i_rst_n = 1'b1;

    // Forwarding chain at distances 1, 2 and 3
    issue(enc(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd1, {4'd4, 8'h3F}));
    issue(enc(COND_AL, 1'b0, OP_ADD, 1'b0, 4'd1, 4'd2, sh(5'd3, SH_LSL, 4'd1)));
    issue(enc(COND_AL, 1'b0, OP_EOR, 1'b0, 4'd1, 4'd3, sh(5'd7, SH_ROR, 4'd2)));
    issue(enc(COND_AL, 1'b0, OP_SUB, 1'b0, 4'd1, 4'd4, sh(5'd2, SH_ASR, 4'd3)));
    issue(enc(COND_AL, 1'b0, OP_RSB, 1'b0, 4'd4, 4'd15, sh(5'd1, SH_LSR, 4'd2)));

    // Every used condition with Z set, then with N set and C clear
    issue(enc(COND_AL, 1'b1, OP_MOV, 1'b1, 4'd0, 4'd6, 12'd0));
    for (int c = 0; c < 15; c++) begin
      issue(enc(4'(c), 1'b1, OP_ADD, 1'b0, 4'd8, 4'd8, 12'd1));
    end
    issue(enc(COND_AL, 1'b1, OP_SUB, 1'b1, 4'd6, 4'd9, 12'd1));
    for (int c = 0; c < 15; c++) begin
      issue(enc(4'(c), 1'b1, (c % 2) ? OP_ADC : OP_SBC, 1'b1, 4'd9, 4'd10, 12'd3));
    end

    // Carry users and logical ops keeping C and V
    issue(enc(COND_AL, 1'b0, OP_RSC, 1'b1, 4'd9, 4'd11, sh(5'd0, SH_ROR, 4'd1)));
    issue(enc(COND_AL, 1'b0, OP_ADC, 1'b1, 4'd9, 4'd12, sh(5'd31, SH_ASR, 4'd9)));
    issue(enc(COND_AL, 1'b0, OP_AND, 1'b1, 4'd9, 4'd13, sh(5'd4, SH_LSR, 4'd1)));
    issue(enc(COND_AL, 1'b1, OP_MVN, 1'b1, 4'd0, 4'd14, {4'd1, 8'h80}));

    // No-ops
    bubble();
    issue(enc(COND_AL, 1'b0, OP_CMP, 1'b1, 4'd1, 4'd5, sh(5'd0, SH_LSL, 4'd2)));
    issue({4'(COND_AL), 2'b01, 26'h3ABCDEF});
    issue(enc(COND_AL, 1'b1, OP_TST, 1'b1, 4'd1, 4'd7, 12'hFFF));

    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (rand_bits(3) == 0) begin
        bubble();
      end else begin
        issue(random_word());
      end
    end
    repeat (4) bubble();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- arm_dp_core.f
+incdir+tb
logic/isa_pkg.sv
logic/core_pkg.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/decode_stage.sv
logic/barrel_shifter.sv
logic/alu.sv
logic/execute_stage.sv
logic/arm_dp_core.sv
tb/tb_arm_dp_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_arm_dp_core
FILELIST  ?= arm_dp_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
